/* logic/memPkg.sv */
`default_nettype none

package memPkg;

    // --------------------------------------------------
    // Bus widths
    // --------------------------------------------------
    localparam int DATA_W = 32;  // Data word width.
    localparam int BE_W   = 4;   // One enable per byte lane.

    // --------------------------------------------------
    // Operation classes
    // --------------------------------------------------
    // Only loads and stores reach the data port.
    typedef enum logic [1:0] {
        OP_LOAD  = 2'd0,
        OP_STORE = 2'd1,
        OP_OTHER = 2'd2
    } opClassT;

    // --------------------------------------------------
    // Access widths
    // --------------------------------------------------
    // Encoded exactly as funct3 of RV32I loads and stores,
    // so the decoder can cast the field directly.
    typedef enum logic [2:0] {
        ACC_B  = 3'b000,  // Signed byte.
        ACC_H  = 3'b001,  // Signed halfword.
        ACC_W  = 3'b010,  // Full word.
        ACC_BU = 3'b100,  // Unsigned byte.
        ACC_HU = 3'b101   // Unsigned halfword.
    } accessT;

endpackage

`default_nettype wire

/* logic/memBusIf.sv */
`timescale 1ns/1ps
`default_nettype none

// One memory request channel. ren or wen is a level held until
// ready pulses; rdata is only valid in the ready cycle.
interface memBusIf #(
    parameter int addrWidth = 16
) ();

    logic [addrWidth-1:0]      addr;    // Byte address.
    logic [memPkg::DATA_W-1:0] wdata;   // Store data.
    logic [memPkg::BE_W-1:0]   byteEn;  // Lane enables for writes.
    logic                      ren;     // Read request level.
    logic                      wen;     // Write request level.
    logic [memPkg::DATA_W-1:0] rdata;   // Read data.
    logic                      ready;   // One-cycle completion pulse.

    // Side that raises the request.
    modport requester (
        output addr, wdata, byteEn, ren, wen,
        input  rdata, ready
    );

    // Side that answers it.
    modport responder (
        input  addr, wdata, byteEn, ren, wen,
        output rdata, ready
    );

endinterface

`default_nettype wire

/* logic/opDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module opDecoder (
    input  logic [memPkg::DATA_W-1:0] instr_i,
    output memPkg::opClassT           opClass_o,
    output memPkg::accessT            access_o
);

    // --------------------------------------------------
    // RV32I major opcodes of interest
    // --------------------------------------------------
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       storeWidthOk;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];

    // Width codes share funct3 encoding.
    assign access_o = memPkg::accessT'(funct3);

    // Stores only exist as SB, SH and SW.
    assign storeWidthOk = (funct3 <= 3'(memPkg::ACC_W));

    always_comb begin
        case (opcode)
            OPC_LOAD: begin
                opClass_o = memPkg::OP_LOAD;
            end
            OPC_STORE: begin
                if (storeWidthOk) begin
                    opClass_o = memPkg::OP_STORE;
                end else begin
                    opClass_o = memPkg::OP_OTHER;  // Reserved store width.
                end
            end
            default: begin
                opClass_o = memPkg::OP_OTHER;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/requestUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module requestUnit #(
    parameter int addrWidth = 16
) (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic [addrWidth-1:0]      fetchAddr_i,
    input  logic [addrWidth-1:0]      dataAddr_i,
    input  logic [memPkg::DATA_W-1:0] storeData_i,
    input  memPkg::opClassT           opClass_i,
    input  memPkg::accessT            access_i,
    output logic [memPkg::DATA_W-1:0] instrWord_o,
    output memPkg::accessT            access_o,
    output logic [memPkg::DATA_W-1:0] instr_o,
    output logic                      instrReady_o,
    output logic [memPkg::DATA_W-1:0] loadData_o,
    output logic                      dataReady_o,
    memBusIf.requester                fetchBus,
    memBusIf.requester                dataBus
);

    logic [addrWidth-1:0]      fetchAddrQ;
    logic [addrWidth-1:0]      dataAddrQ;
    logic [memPkg::DATA_W-1:0] storeDataQ;
    logic [memPkg::DATA_W-1:0] instrQ;
    memPkg::accessT            accessQ;
    logic                      dataRenQ;
    logic                      dataWenQ;
    logic                      dataPending;
    logic                      startData;

    assign dataPending = dataRenQ | dataWenQ;
    // A fresh load or store, seen while its word is on instr_o.
    assign startData = instrReady_o &&
                       (opClass_i == memPkg::OP_LOAD || opClass_i == memPkg::OP_STORE);

    // --------------------------------------------------
    // Fetch channel
    // --------------------------------------------------
    // Fetch pauses while a new word is decoded and while data is up.
    assign fetchBus.addr   = fetchAddrQ;
    assign fetchBus.wdata  = '0;
    assign fetchBus.byteEn = '1;  // Whole-word reads.
    assign fetchBus.ren    = ~(instrReady_o | dataPending);
    assign fetchBus.wen    = 1'b0;

    // --------------------------------------------------
    // Data channel
    // --------------------------------------------------
    assign dataBus.addr   = dataAddrQ;
    assign dataBus.wdata  = storeDataQ;
    assign dataBus.byteEn = '1;  // Narrowed later by lane.
    assign dataBus.ren    = dataRenQ;
    assign dataBus.wen    = dataWenQ;

    assign instrWord_o = instrQ;
    assign instr_o     = instrQ;
    assign access_o    = accessQ;

    // Control state.
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            instrReady_o <= 1'b0;
            dataReady_o  <= 1'b0;
            dataRenQ     <= 1'b0;
            dataWenQ     <= 1'b0;
        end else begin
            instrReady_o <= fetchBus.ready;
            dataReady_o  <= dataBus.ready;
            if (startData) begin
                dataRenQ <= (opClass_i == memPkg::OP_LOAD);
                dataWenQ <= (opClass_i == memPkg::OP_STORE);
            end else if (dataBus.ready) begin
                dataRenQ <= 1'b0;  // Level drops after the pulse.
                dataWenQ <= 1'b0;
            end
        end
    end

    // Payload registers.
    always_ff @(posedge CLK) begin
        fetchAddrQ <= fetchAddr_i;
        if (fetchBus.ready) begin
            instrQ <= fetchBus.rdata;
        end
        if (startData) begin
            dataAddrQ  <= dataAddr_i;  // Core holds these with instrReady_o.
            storeDataQ <= storeData_i;
            accessQ    <= access_i;
        end
        if (dataBus.ready && dataRenQ) begin
            loadData_o <= dataBus.rdata;
        end
    end

endmodule

`default_nettype wire

/* logic/loadStoreAlign.sv */
`timescale 1ns/1ps
`default_nettype none

module loadStoreAlign #(
    parameter int addrWidth = 16
) (
    input  memPkg::accessT access_i,
    memBusIf.responder     core,
    memBusIf.requester     mem
);

    logic [1:0]                byteOff;
    logic [memPkg::BE_W-1:0]   laneEn;
    logic [memPkg::DATA_W-1:0] laneData;
    logic [memPkg::DATA_W-1:0] byteShift;
    logic [memPkg::DATA_W-1:0] halfShift;

    assign byteOff = core.addr[1:0];

    // --------------------------------------------------
    // Store side
    // --------------------------------------------------
    always_comb begin
        case (access_i)
            memPkg::ACC_B, memPkg::ACC_BU: begin
                laneData = {4{core.wdata[7:0]}};
                laneEn   = 4'b0001 << byteOff;
            end
            memPkg::ACC_H, memPkg::ACC_HU: begin
                laneData = {2{core.wdata[15:0]}};
                laneEn   = byteOff[1] ? 4'b1100 : 4'b0011;  // Aligned down.
            end
            default: begin
                laneData = core.wdata;
                laneEn   = 4'b1111;
            end
        endcase
    end

    assign mem.addr   = {core.addr[addrWidth-1:2], 2'b00};  // Word address.
    assign mem.wdata  = laneData;
    assign mem.byteEn = laneEn & core.byteEn;
    assign mem.ren    = core.ren;
    assign mem.wen    = core.wen;

    // --------------------------------------------------
    // Load side
    // --------------------------------------------------
    assign byteShift = mem.rdata >> {byteOff, 3'b000};
    assign halfShift = mem.rdata >> {byteOff[1], 4'b0000};

    always_comb begin
        case (access_i)
            memPkg::ACC_B: begin
                core.rdata = {{24{byteShift[7]}}, byteShift[7:0]};
            end
            memPkg::ACC_BU: begin
                core.rdata = {24'b0, byteShift[7:0]};
            end
            memPkg::ACC_H: begin
                core.rdata = {{16{halfShift[15]}}, halfShift[15:0]};
            end
            memPkg::ACC_HU: begin
                core.rdata = {16'b0, halfShift[15:0]};
            end
            default: begin
                core.rdata = mem.rdata;  // Word load.
            end
        endcase
    end

    assign core.ready = mem.ready;

endmodule

`default_nettype wire

/* logic/memArbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module memArbiter #(
    parameter int addrWidth = 16
) (
    input  logic                      CLK,
    input  logic                      nRST,
    memBusIf.responder                fetchBus,
    memBusIf.responder                dataBus,
    output logic [addrWidth-1:0]      ramAddr_o,
    output logic [memPkg::DATA_W-1:0] ramWdata_o,
    output logic [memPkg::BE_W-1:0]   ramByteEn_o,
    output logic                      ramRen_o,
    output logic                      ramWen_o,
    input  logic [memPkg::DATA_W-1:0] ramRdata_i,
    input  logic                      ramReady_i
);

    typedef enum logic [1:0] {
        OWN_IDLE  = 2'd0,
        OWN_FETCH = 2'd1,
        OWN_DATA  = 2'd2
    } ownerT;

    ownerT owner;
    ownerT ownerNext;
    logic  dataReq;
    logic  fetchReq;
    logic  selData;

    assign dataReq  = dataBus.ren | dataBus.wen;
    assign fetchReq = fetchBus.ren | fetchBus.wen;

    // --------------------------------------------------
    // Owner FSM
    // --------------------------------------------------
    always_comb begin
        ownerNext = owner;
        if (owner == OWN_IDLE) begin
            if (dataReq) begin
                ownerNext = OWN_DATA;  // Data wins a tie.
            end else if (fetchReq) begin
                ownerNext = OWN_FETCH;
            end
        end else if (ramReady_i) begin
            ownerNext = OWN_IDLE;  // Release after the pulse.
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            owner <= OWN_IDLE;
        end else begin
            owner <= ownerNext;
        end
    end

    // --------------------------------------------------
    // Port mux
    // --------------------------------------------------
    assign selData = (owner == OWN_DATA);

    assign ramAddr_o   = selData ? dataBus.addr   : fetchBus.addr;
    assign ramWdata_o  = selData ? dataBus.wdata  : fetchBus.wdata;
    assign ramByteEn_o = selData ? dataBus.byteEn : fetchBus.byteEn;  // All ones on fetch.
    assign ramRen_o    = (owner != OWN_IDLE) && (selData ? dataBus.ren : fetchBus.ren);
    assign ramWen_o    = (owner != OWN_IDLE) && (selData ? dataBus.wen : fetchBus.wen);

    // Ready only reaches the channel that owns the port.
    assign fetchBus.ready = ramReady_i && (owner == OWN_FETCH);
    assign dataBus.ready  = ramReady_i && selData;
    assign fetchBus.rdata = ramRdata_i;
    assign dataBus.rdata  = ramRdata_i;

endmodule

`default_nettype wire

/* logic/memSubsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module memSubsystem #(
    parameter int addrWidth = 16
) (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic [addrWidth-1:0]      fetchAddr_i,
    input  logic [addrWidth-1:0]      dataAddr_i,
    input  logic [memPkg::DATA_W-1:0] storeData_i,
    output logic [memPkg::DATA_W-1:0] instr_o,
    output logic                      instrReady_o,
    output logic [memPkg::DATA_W-1:0] loadData_o,
    output logic                      dataReady_o,
    output logic [addrWidth-1:0]      ramAddr_o,
    output logic [memPkg::DATA_W-1:0] ramWdata_o,
    output logic [memPkg::BE_W-1:0]   ramByteEn_o,
    output logic                      ramRen_o,
    output logic                      ramWen_o,
    input  logic [memPkg::DATA_W-1:0] ramRdata_i,
    input  logic                      ramReady_i
);

    logic [memPkg::DATA_W-1:0] instrWord;
    memPkg::opClassT           opClass;
    memPkg::accessT            accessDec;  // Width of the word just fetched.
    memPkg::accessT            accessReq;  // Width of the pending access.

    // --------------------------------------------------
    // Channels
    // --------------------------------------------------
    memBusIf #(.addrWidth(addrWidth)) fetchBus ();
    memBusIf #(.addrWidth(addrWidth)) dataBusCore ();
    memBusIf #(.addrWidth(addrWidth)) dataBusMem ();

    opDecoder decoder0 (
        .instr_i  (instrWord),
        .opClass_o(opClass),
        .access_o (accessDec)
    );

    requestUnit #(.addrWidth(addrWidth)) reqUnit0 (
        .CLK(CLK), .nRST(nRST),
        .fetchAddr_i(fetchAddr_i), .dataAddr_i(dataAddr_i),
        .storeData_i(storeData_i),
        .opClass_i(opClass), .access_i(accessDec),
        .instrWord_o(instrWord), .access_o(accessReq),
        .instr_o(instr_o), .instrReady_o(instrReady_o),
        .loadData_o(loadData_o), .dataReady_o(dataReady_o),
        .fetchBus(fetchBus.requester), .dataBus(dataBusCore.requester)
    );

    loadStoreAlign #(.addrWidth(addrWidth)) align0 (
        .access_i(accessReq),
        .core    (dataBusCore.responder),
        .mem     (dataBusMem.requester)
    );

    memArbiter #(.addrWidth(addrWidth)) arb0 (
        .CLK(CLK), .nRST(nRST),
        .fetchBus(fetchBus.responder), .dataBus(dataBusMem.responder),
        .ramAddr_o(ramAddr_o), .ramWdata_o(ramWdata_o), .ramByteEn_o(ramByteEn_o),
        .ramRen_o(ramRen_o), .ramWen_o(ramWen_o),
        .ramRdata_i(ramRdata_i), .ramReady_i(ramReady_i)
    );

endmodule

`default_nettype wire

/* sim/tbClock.sv */
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
    parameter int periodNs    = 8,
    parameter int resetCycles = 5
) (
    output logic CLK_o,
    output logic nRST_o
);

    initial begin
        CLK_o = 1'b0;
        forever #(periodNs / 2) CLK_o = ~CLK_o;
    end

    // Released just after an edge, clear of the sampling point.
    initial begin
        nRST_o = 1'b0;
        repeat (resetCycles) @(posedge CLK_o);
        #1 nRST_o = 1'b1;
    end

endmodule

`default_nettype wire

/* sim/memSubsystem_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module memSubsystem_asserts #(
    parameter int addrWidth = 16
) (
    input logic                      CLK,
    input logic                      nRST,
    input logic [addrWidth-1:0]      ramAddr_i,
    input logic [memPkg::DATA_W-1:0] ramWdata_i,
    input logic [memPkg::BE_W-1:0]   ramByteEn_i,
    input logic                      ramRen_i,
    input logic                      ramWen_i,
    input logic                      ramReady_i
);

    // Only one kind of access owns the port.
    noReadWriteOverlap: assert property (
        @(posedge CLK) disable iff (!nRST)
        !(ramRen_i && ramWen_i)
    ) else $error("ramRen_o and ramWen_o are high in the same cycle");

    // A strobe and its address hold until the ready pulse.
    requestHeld: assert property (
        @(posedge CLK) disable iff (!nRST)
        (ramRen_i || ramWen_i) && !ramReady_i |=>
            $stable(ramRen_i) && $stable(ramWen_i) && $stable(ramAddr_i)
    ) else $error("strobe or address changed before ramReady_i");

    // Write payload holds as well.
    writeDataHeld: assert property (
        @(posedge CLK) disable iff (!nRST)
        ramWen_i && !ramReady_i |=> $stable(ramWdata_i) && $stable(ramByteEn_i)
    ) else $error("write data or byte enables changed before ramReady_i");

endmodule

bind memSubsystem memSubsystem_asserts #(.addrWidth(addrWidth)) asserts0 (
    .CLK        (CLK),
    .nRST       (nRST),
    .ramAddr_i  (ramAddr_o),
    .ramWdata_i (ramWdata_o),
    .ramByteEn_i(ramByteEn_o),
    .ramRen_i   (ramRen_o),
    .ramWen_i   (ramWen_o),
    .ramReady_i (ramReady_i)
);

`default_nettype wire

/* sim/memSubsystemTb.sv */
`timescale 1ns/1ps
`default_nettype none

module memSubsystemTb;

    localparam int ADDR_W       = 16;
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_ROWS     = 20;
    localparam int TIMEOUT_NS   = (NUM_ROWS * 40 + RESET_CYCLES) * CLK_PERIOD;

    // RV32I funct3 codes of loads and stores.
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    typedef enum logic [1:0] {KIND_LOAD, KIND_STORE, KIND_OTHER} kindT;

    typedef struct {
        kindT              kind;       // Expected class.
        logic [31:0]       instr;
        logic [ADDR_W-1:0] fetchAddr;
        logic [ADDR_W-1:0] dataAddr;
        logic [31:0]       storeData;
    } rowT;

    logic              CLK;
    logic              nRST;
    logic [ADDR_W-1:0] fetchAddr;
    logic [ADDR_W-1:0] dataAddr;
    logic [31:0]       storeData;
    logic [31:0]       instr;
    logic              instrReady;
    logic [31:0]       loadData;
    logic              dataReady;
    logic [ADDR_W-1:0] ramAddr;
    logic [31:0]       ramWdata;
    logic [3:0]        ramByteEn;
    logic              ramRen;
    logic              ramWen;
    logic [31:0]       ramRdata;
    logic              ramReady;

    logic [31:0] ramWords [0:255];  // Memory model contents.
    logic [31:0] shadow [0:255];    // Predicted contents.
    rowT         rows [0:NUM_ROWS-1];
    int          rowCount = 0;
    int          errorCount = 0;
    int          checkCount = 0;
    integer      seed = 32'h41eb_21ba;

    tbClock #(.periodNs(CLK_PERIOD), .resetCycles(RESET_CYCLES)) clock0 (
        .CLK_o (CLK),
        .nRST_o(nRST)
    );

    memSubsystem #(.addrWidth(ADDR_W)) dut0 (
        .CLK(CLK), .nRST(nRST),
        .fetchAddr_i(fetchAddr), .dataAddr_i(dataAddr), .storeData_i(storeData),
        .instr_o(instr), .instrReady_o(instrReady),
        .loadData_o(loadData), .dataReady_o(dataReady),
        .ramAddr_o(ramAddr), .ramWdata_o(ramWdata), .ramByteEn_o(ramByteEn),
        .ramRen_o(ramRen), .ramWen_o(ramWen),
        .ramRdata_i(ramRdata), .ramReady_i(ramReady)
    );

    // --------------------------------------------------
    // Reference rules
    // --------------------------------------------------
    function automatic logic [31:0] encodeLoad(input logic [2:0] f3);
        return {12'h000, 5'd2, f3, 5'd1, 7'b0000011};  // rd x1, base x2.
    endfunction

    function automatic logic [31:0] encodeStore(input logic [2:0] f3);
        return {7'h00, 5'd3, 5'd2, f3, 5'h00, 7'b0100011};  // src x3, base x2.
    endfunction

    // Store rule. Halfwords land on the aligned-down pair of lanes.
    function automatic logic [31:0] mergeStore(input logic [31:0] old, input logic [2:0] f3,
                                               input logic [1:0] off, input logic [31:0] data);
        logic [31:0] result;
        result = old;
        if (f3 == F3_B) begin
            result[int'(off) * 8 +: 8] = data[7:0];
        end else if (f3 == F3_H) begin
            result[int'(off[1]) * 16 +: 16] = data[15:0];
        end else begin
            result = data;
        end
        return result;
    endfunction

    // Load rule.
    function automatic logic [31:0] extractLoad(input logic [31:0] word, input logic [2:0] f3,
                                                input logic [1:0] off);
        logic [7:0]  lane;
        logic [15:0] half;
        logic [31:0] result;
        lane = word[int'(off) * 8 +: 8];
        half = off[1] ? word[31:16] : word[15:0];
        case (f3)
            F3_B:    result = {{24{lane[7]}}, lane};
            F3_BU:   result = {24'h0, lane};
            F3_H:    result = {{16{half[15]}}, half};
            F3_HU:   result = {16'h0, half};
            default: result = word;
        endcase
        return result;
    endfunction

    task automatic addRow(input kindT kind, input logic [31:0] word,
                          input logic [ADDR_W-1:0] dAddr, input logic [31:0] sData);
        rows[rowCount].kind      = kind;
        rows[rowCount].instr     = word;
        rows[rowCount].fetchAddr = 16'h0040 + 16'(rowCount * 4);
        rows[rowCount].dataAddr  = dAddr;
        rows[rowCount].storeData = sData;
        rowCount++;
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        errorCount++;
        $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
    endtask

    task automatic finishRun();
        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    // --------------------------------------------------
    // Memory model
    // --------------------------------------------------
    initial begin : memoryModel
        int latency;
        int word;
        ramReady = 1'b0;
        ramRdata = '0;
        forever begin
            @(posedge CLK);
            #1;
            ramReady = 1'b0;  // Pulse lasts one cycle.
            if (nRST && (ramRen || ramWen)) begin
                latency = 1 + int'($unsigned($random(seed)) % 4);
                repeat (latency) @(posedge CLK);
                #1;
                word = int'(ramAddr[9:2]);
                for (int lane = 0; lane < 4; lane++) begin
                    if (ramWen && ramByteEn[lane]) begin
                        ramWords[word][lane * 8 +: 8] = ramWdata[lane * 8 +: 8];
                    end
                end
                ramRdata = ramWords[word];
                ramReady = 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // Stimulus and checks
    // --------------------------------------------------
    task automatic applyRow(input int idx);
        int word;
        word = int'(rows[idx].fetchAddr[9:2]);
        ramWords[word] = rows[idx].instr;
        shadow[word]   = rows[idx].instr;
        fetchAddr = rows[idx].fetchAddr;
        dataAddr  = rows[idx].dataAddr;
        storeData = rows[idx].storeData;
    endtask

    task automatic waitInstr(input int idx);
        do begin
            @(posedge CLK);
            #1;
            if (ramWen) begin
                errorCount++;
                $display("write on the memory port at %0t ns with no store pending", $time);
            end
            if (dataReady) begin
                errorCount++;
                $display("dataReady_o pulsed at %0t ns with no data access pending", $time);
            end
        end while (!instrReady);
        checkCount++;
        if (instr !== shadow[int'(rows[idx].fetchAddr[9:2])]) begin
            reportMismatch("instr_o", instr, shadow[int'(rows[idx].fetchAddr[9:2])]);
        end
    endtask

    task automatic waitData(input int idx);
        int          word;
        logic [1:0]  off;
        logic [2:0]  f3;
        logic [31:0] expected;
        word = int'(rows[idx].dataAddr[9:2]);
        off  = rows[idx].dataAddr[1:0];
        f3   = rows[idx].instr[14:12];
        do begin
            @(posedge CLK);
            #1;
            if (ramRen && ramAddr == rows[idx].fetchAddr) begin
                errorCount++;
                $display("fetch read issued at %0t ns before row %0d finished", $time, idx);
            end
            if (rows[idx].kind == KIND_LOAD && ramWen) begin
                errorCount++;
                $display("write on the memory port at %0t ns during a load", $time);
            end
        end while (!dataReady);
        checkCount++;
        if (rows[idx].kind == KIND_LOAD) begin
            expected = extractLoad(shadow[word], f3, off);
            if (loadData !== expected) begin
                reportMismatch("loadData_o", loadData, expected);
            end
        end else begin
            shadow[word] = mergeStore(shadow[word], f3, off, rows[idx].storeData);
            if (ramWords[word] !== shadow[word]) begin
                reportMismatch("memory word", ramWords[word], shadow[word]);
            end
        end
    endtask

    initial begin : stimulus
        fetchAddr = '0;
        dataAddr  = '0;
        storeData = '0;
        for (int w = 0; w < 256; w++) begin
            ramWords[w] = 32'h9e37_79b9 * 32'(w + 1);  // Mixes every address bit.
            shadow[w]   = ramWords[w];
        end
        addRow(KIND_STORE, encodeStore(F3_W), 16'h0200, 32'h1122_3344);
        addRow(KIND_LOAD,  encodeLoad(F3_W),  16'h0200, 32'h0);
        addRow(KIND_STORE, encodeStore(F3_B), 16'h0205, 32'h5555_55ab);
        addRow(KIND_LOAD,  encodeLoad(F3_W),  16'h0204, 32'h0);
        addRow(KIND_STORE, encodeStore(F3_H), 16'h020a, 32'h3333_beef);
        addRow(KIND_LOAD,  encodeLoad(F3_W),  16'h0208, 32'h0);
        addRow(KIND_OTHER, 32'h0010_0093,     16'h0300, 32'h0);  // ALU immediate.
        addRow(KIND_LOAD,  encodeLoad(F3_B),  16'h0205, 32'h0);
        addRow(KIND_LOAD,  encodeLoad(F3_BU), 16'h0205, 32'h0);
        addRow(KIND_LOAD,  encodeLoad(F3_H),  16'h020a, 32'h0);
        addRow(KIND_LOAD,  encodeLoad(F3_HU), 16'h020a, 32'h0);
        addRow(KIND_OTHER, 32'h0000_0463,     16'h0300, 32'h0);  // Branch.
        addRow(KIND_OTHER, encodeStore(3'b011), 16'h0300, 32'hffff_ffff);
        addRow(KIND_STORE, encodeStore(F3_B), 16'h0213, 32'h0000_007f);
        addRow(KIND_LOAD,  encodeLoad(F3_B),  16'h0213, 32'h0);
        addRow(KIND_LOAD,  encodeLoad(F3_H),  16'h020b, 32'h0);  // Misaligned.
        addRow(KIND_STORE, encodeStore(F3_H), 16'h0221, 32'h0000_8001);
        addRow(KIND_LOAD,  encodeLoad(F3_W),  16'h0220, 32'h0);
        addRow(KIND_LOAD,  encodeLoad(F3_HU), 16'h02f2, 32'h0);
        addRow(KIND_LOAD,  encodeLoad(F3_B),  16'h03ff, 32'h0);
        applyRow(0);  // First fetch starts right after reset.
        @(posedge nRST);
        @(posedge CLK);
        #1;
        checkCount++;
        if (instrReady !== 1'b0 || dataReady !== 1'b0 || ramWen !== 1'b0) begin
            errorCount++;
            $display("outputs not idle after reset at %0t ns", $time);
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (i > 0) begin
                applyRow(i);
            end
            waitInstr(i);
            if (rows[i].kind != KIND_OTHER) begin
                waitData(i);
            end
        end
        finishRun();
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        errorCount++;
        $display("timeout at %0t ns, the DUT stopped answering", $time);
        finishRun();
    end

endmodule

`default_nettype wire

/* build.f */
logic/memPkg.sv
logic/memBusIf.sv
logic/opDecoder.sv
logic/requestUnit.sv
logic/loadStoreAlign.sv
logic/memArbiter.sv
logic/memSubsystem.sv
sim/tbClock.sv
sim/memSubsystem_asserts.sv
sim/memSubsystemTb.sv

/* Makefile */
# Verilator build and run for the memory subsystem testbench.
VERILATOR ?= verilator
TOP       ?= memSubsystemTb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes.
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TB FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
